// ==== count_mixer.sv ====
// ##################
// Registers the host outputs with the trojan load XORed into the count.
// ##################
`timescale 1ns/1ps
`include "counter_host_params.svh"

module count_mixer (
    input  logic                              clk,
    input  logic                              rst,
    input  counter_host_pkg::counter_status_t counter_status,
    input  counter_host_pkg::load_t           load,
    output counter_host_pkg::host_out_t       host_out
);

    counter_host_pkg::count_t    load_mask;
    counter_host_pkg::host_out_t host_next;

    // Only the low count bits of the load reach the output
    assign load_mask = load[`COUNT_WIDTH-1:0];

    always_comb begin
        host_next.count    = counter_status.count ^ load_mask;
        host_next.overflow = counter_status.overflow;
        host_next.pulse    = counter_status.pulse;
    end

    // Updates every clock, enable only affects the counter side
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            host_out <= '0;
        end else begin
            host_out <= host_next;
        end
    end

endmodule

// ==== counter_host_asserts.sv ====
// ####################
// Concurrent checks on the counter flags and the trojan state,
// bound into event_counter and trojan0.
// ####################
`timescale 1ns/1ps

module counter_host_asserts (
    input logic                            clk,
    input logic                            rst,
    input logic                            enable,
    input counter_host_pkg::count_t        count,
    input logic                            overflow,
    input logic                            pulse,
    input counter_host_pkg::trojan_state_e state
);

    // Period wrap clears the pulse on the next enabled edge
    pulse_single: assert property (
        @(posedge clk) disable iff (rst)
        (enable && pulse) |=> !pulse
    ) else $error("pulse high on two consecutive enabled cycles");

    // Overflow only rises after the count was all ones
    overflow_after_wrap: assert property (
        @(posedge clk) disable iff (rst)
        $rose(overflow) |-> ($past(count) == '1)
    ) else $error("overflow set without a count of all ones before it");

    armed_sticky: assert property (
        @(posedge clk) disable iff (rst)
        (state == counter_host_pkg::armed) |=> (state == counter_host_pkg::armed)
    ) else $error("trojan left the armed state without reset");

endmodule

// Counter side, trojan state tied to dormant
bind event_counter counter_host_asserts u_counter_checks (
    .clk      (clk),
    .rst      (rst),
    .enable   (enable),
    .count    (count_q),
    .overflow (overflow_q),
    .pulse    (pulse_q),
    .state    (counter_host_pkg::dormant)
);

// Trojan side, counter inputs tied off
bind trojan0 counter_host_asserts u_trojan_checks (
    .clk      (clk),
    .rst      (rst),
    .enable   (1'b0),
    .count    ('0),
    .overflow (1'b0),
    .pulse    (1'b0),
    .state    (state)
);

// ==== counter_host_params.svh ====
// ##################
// Fixed widths, seeds and constants of the counter host.
// Included by the package and by every RTL block that needs a value.
// ##################
`ifndef COUNTER_HOST_PARAMS_SVH
`define COUNTER_HOST_PARAMS_SVH

// Main counter and published count width
`define COUNT_WIDTH 12

// Enabled cycles between two periodic pulses
`define COUNT_PERIOD 100

// Key register value after reset
`define KEY_SEED 128'h1357_9bdf_0246_8ace_1357_9bdf_0246_8ace

// Leak LFSR start value, must not be zero
`define LEAK_SEED 64'hc3a5_9e17_6b2d_f041

// Key low byte that arms the trojan
`define TRIGGER_BYTE 8'he3

// Width of the key and of the trojan load
`define KEY_WIDTH 128
`define LOAD_WIDTH 64

// Byte of the count folded into the key each enabled cycle
`define FOLD_WIDTH 8

`endif

// ==== counter_host_pkg.sv ====
// ##################
// Types shared between the counter host RTL and its testbench.
// ##################
`include "counter_host_params.svh"

package counter_host_pkg;

    // Raw and published count
    typedef logic [`COUNT_WIDTH-1:0] count_t;

    // Key driven by the sequencer into the trojan
    typedef logic [`KEY_WIDTH-1:0] key_t;

    // Trojan leak load
    typedef logic [`LOAD_WIDTH-1:0] load_t;

    // Counter results handed to the sequencer and the mixer
    typedef struct packed {
        count_t count;
        logic   overflow;
        logic   pulse;
    } counter_status_t;

    // Registered host output
    typedef struct packed {
        count_t count;
        logic   overflow;
        logic   pulse;
    } host_out_t;

    // Trojan trigger state, armed is sticky until reset
    typedef enum logic {
        dormant = 1'b0,
        armed   = 1'b1
    } trojan_state_e;

endpackage

// ==== counter_host_stimulus.txt ====
# Columns: kind length expected_pulses expected_overflows
# Kind E enables every cycle, D disables, R takes enable from the LFSR
# Counting from reset, first pulses
E 250 2 0
D 40 0 0
E 300 3 0
D 25 0 0

# Long run across the counter wrap from all ones to zero
E 4200 42 1
D 30 0 0

# Brings the period counter back to phase zero
E 50 1 0

# Random parts stay short of the next pulse in total
R 40 0 0
E 200 2 0
D 15 0 0
R 30 0 0
E 100 1 0
R 29 0 0

# Whole periods give a fixed pulse count after random phase
E 400 4 0
D 20 0 0

// ==== event_counter.sv ====
// ##################
// Free-running event counter with overflow flag and periodic pulse.
// All state advances only on cycles with enable high.
// ##################
`timescale 1ns/1ps
`include "counter_host_params.svh"

module event_counter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              enable,
    output counter_host_pkg::counter_status_t counter_status
);

    localparam counter_host_pkg::count_t count_max    = {`COUNT_WIDTH{1'b1}};
    localparam counter_host_pkg::count_t period_last  = `COUNT_WIDTH'(`COUNT_PERIOD - 1);

    counter_host_pkg::count_t count_q;
    counter_host_pkg::count_t period_q;
    logic                     overflow_q;
    logic                     pulse_q;

    logic period_wrap;

    // Period counter at its last value before the wrap
    assign period_wrap = (period_q == period_last);

    // Main counter and overflow
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_q    <= '0;
            overflow_q <= 1'b0;
        end else if (enable) begin
            count_q    <= count_q + 1'b1;
            // Flag the step from all ones back to zero
            overflow_q <= (count_q == count_max);
        end
    end

    // Period counter and pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            period_q <= '0;
            pulse_q  <= 1'b0;
        end else if (enable) begin
            if (period_wrap) begin
                period_q <= '0;
                pulse_q  <= 1'b1;
            end else begin
                period_q <= period_q + 1'b1;
                pulse_q  <= 1'b0;
            end
        end
    end

    // Flags hold while disabled, so a high flag stays high
    assign counter_status.count    = count_q;
    assign counter_status.overflow = overflow_q;
    assign counter_status.pulse    = pulse_q;

endmodule

// ==== filelist.f ====
+incdir+.
counter_host_pkg.sv
event_counter.sv
key_sequencer.sv
trojan0.sv
count_mixer.sv
trojan0_counter_host.sv
counter_host_asserts.sv
tb_counter_host.sv

// ==== key_sequencer.sv ====
// ##################
// 128-bit key register, rotated bytewise with the count byte folded in.
// ##################
`timescale 1ns/1ps
`include "counter_host_params.svh"

module key_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     enable,
    input  counter_host_pkg::count_t count,
    output counter_host_pkg::key_t   key
);

    localparam int key_bits  = `KEY_WIDTH;
    localparam int fold_bits = `FOLD_WIDTH;

    logic [fold_bits-1:0]    top_byte;
    logic [fold_bits-1:0]    fold_byte;
    counter_host_pkg::key_t  key_next;

    // Outgoing top byte mixed with the low count byte
    assign top_byte  = key[key_bits-1 -: fold_bits];
    assign fold_byte = top_byte ^ count[fold_bits-1:0];

    // Shift left one byte, new low byte from the fold
    assign key_next = {key[key_bits-fold_bits-1:0], fold_byte};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key <= `KEY_SEED;
        end else if (enable) begin
            key <= key_next;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the counter host testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_counter_host \
    -o sim_counter_host

out=$(./obj_dir/sim_counter_host 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi

// ==== tb_counter_host.sv ====
// ####################
// Testbench for the counter host. Runs the segments of the stimulus file
// against a cycle model and compares host_out on every cycle.
// ####################
`timescale 1ns/1ps
`include "counter_host_params.svh"

module tb_counter_host;

    localparam int clk_half      = 5;
    localparam int clk_period    = 2 * clk_half;
    localparam int reset_cycles  = 10;
    localparam int flush_cycles  = 3;
    localparam int margin_cycles = 50;

    localparam counter_host_pkg::count_t count_max   = '1;
    localparam counter_host_pkg::count_t period_last = `COUNT_WIDTH'(`COUNT_PERIOD - 1);

    logic                        clk;
    logic                        rst;
    logic                        enable;
    counter_host_pkg::host_out_t host_out;

    // Reference model state
    counter_host_pkg::count_t        m_count;
    counter_host_pkg::count_t        m_period;
    logic                            m_ovf;
    logic                            m_pulse;
    counter_host_pkg::key_t          m_key;
    counter_host_pkg::load_t         m_lfsr;
    counter_host_pkg::trojan_state_e m_state;
    counter_host_pkg::host_out_t     m_out;

    logic        applied_en;
    int          seg_pipe[3];
    logic        last_pulse;
    logic        last_overflow;
    logic [31:0] rand_state;
    logic        verdict_printed;

    // Segment records from the stimulus file
    logic [7:0] kinds[$];
    int         lens[$];
    int         exp_pulses[$];
    int         exp_overflows[$];

    // Flag rises seen on host_out, per segment
    int         got_pulses[$];
    int         got_overflows[$];

    trojan0_counter_host u_trojan0_counter_host (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .host_out (host_out)
    );

    always #(clk_half) clk = ~clk;

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] next_random_state(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic stop_with_failure(input string reason);
        verdict_printed = 1'b1;
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("[FAIL] %s expected 0x%0h actual 0x%0h",
                                        name, expected, actual));
        end
    endtask

    task automatic model_reset();
        m_count  = '0;
        m_period = '0;
        m_ovf    = 1'b0;
        m_pulse  = 1'b0;
        m_key    = `KEY_SEED;
        m_lfsr   = `LEAK_SEED;
        m_state  = counter_host_pkg::dormant;
        m_out    = '0;
    endtask

    // One clock edge of the host, all terms taken from before the edge
    task automatic model_update(input logic en);
        counter_host_pkg::load_t leak_load;
        logic                    feedback;
        logic [7:0]              fold_byte;
        if (m_state == counter_host_pkg::armed) begin
            leak_load = m_lfsr ^ m_key[63:0];
        end else begin
            leak_load = '0;
        end
        m_out.count    = m_count ^ leak_load[`COUNT_WIDTH-1:0];
        m_out.overflow = m_ovf;
        m_out.pulse    = m_pulse;
        if (m_key[7:0] == `TRIGGER_BYTE) begin
            m_state = counter_host_pkg::armed;
        end
        // Leak LFSR ignores enable
        feedback = m_lfsr[63] ^ m_lfsr[62] ^ m_lfsr[60] ^ m_lfsr[59];
        m_lfsr   = {m_lfsr[62:0], feedback};
        if (en) begin
            fold_byte = m_key[127:120] ^ m_count[7:0];
            m_key     = {m_key[119:0], fold_byte};
            m_ovf     = (m_count == count_max);
            m_count   = m_count + 1'b1;
            m_pulse   = (m_period == period_last);
            if (m_pulse) begin
                m_period = '0;
            end else begin
                m_period = m_period + 1'b1;
            end
        end
    endtask

    task automatic compare_outputs();
        check_value("host_out.count", 64'(m_out.count), 64'(host_out.count));
        check_value("host_out.overflow", 64'(m_out.overflow), 64'(host_out.overflow));
        check_value("host_out.pulse", 64'(m_out.pulse), 64'(host_out.pulse));
    endtask

    task automatic check_segment(input int idx);
        check_value($sformatf("segment %0d pulses", idx),
                    64'(exp_pulses[idx]), 64'(got_pulses[idx]));
        check_value($sformatf("segment %0d overflows", idx),
                    64'(exp_overflows[idx]), 64'(got_overflows[idx]));
    endtask

    // Drive one cycle, compare at the falling edge
    task automatic step(input logic en, input int seg);
        int done_seg;
        done_seg = seg_pipe[2];
        @(posedge clk);
        model_update(applied_en);
        enable <= en;
        applied_en = en;
        // Flags on host_out trail the driven enable by two clocks
        seg_pipe[2] = seg_pipe[1];
        seg_pipe[1] = seg_pipe[0];
        seg_pipe[0] = seg;
        if (done_seg >= 0 && done_seg != seg_pipe[2]) begin
            check_segment(done_seg);
        end
        @(negedge clk);
        compare_outputs();
        if (seg_pipe[2] >= 0 && host_out.pulse && !last_pulse) begin
            got_pulses[seg_pipe[2]] = got_pulses[seg_pipe[2]] + 1;
        end
        if (seg_pipe[2] >= 0 && host_out.overflow && !last_overflow) begin
            got_overflows[seg_pipe[2]] = got_overflows[seg_pipe[2]] + 1;
        end
        last_pulse    = host_out.pulse;
        last_overflow = host_out.overflow;
    endtask

    task automatic run_segment(input int idx);
        logic en;
        for (int i = 0; i < lens[idx]; i++) begin
            if (kinds[idx] == "E") begin
                en = 1'b1;
            end else if (kinds[idx] == "D") begin
                en = 1'b0;
            end else begin
                rand_state = next_random_state(rand_state);
                en = rand_state[0];
            end
            step(en, idx);
        end
    endtask

    task automatic load_records();
        int         fd;
        int         got;
        string      line;
        logic [7:0] kind;
        int         len;
        int         pulses;
        int         overflows;
        fd = $fopen("counter_host_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open the stimulus file counter_host_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                got = $fgets(line, fd);
                // Skip comments and blank lines
                if (got > 0 && line[0] != "#" && line[0] != "\n") begin
                    got = $sscanf(line, "%c %d %d %d", kind, len, pulses, overflows);
                    if (got != 4 || (kind != "E" && kind != "D" && kind != "R")) begin
                        stop_with_failure({"Stimulus line could not be read: ", line});
                    end else begin
                        kinds.push_back(kind);
                        lens.push_back(len);
                        exp_pulses.push_back(pulses);
                        exp_overflows.push_back(overflows);
                        got_pulses.push_back(0);
                        got_overflows.push_back(0);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int     total;
        longint limit;
        clk             = 1'b0;
        rst             = 1'b1;
        enable          = 1'b0;
        applied_en      = 1'b0;
        last_pulse      = 1'b0;
        last_overflow   = 1'b0;
        seg_pipe        = '{-1, -1, -1};
        verdict_printed = 1'b0;
        rand_state      = 32'h1f8f_9404;
        model_reset();
        load_records();
        total = 0;
        foreach (lens[i]) begin
            total += lens[i];
        end
        limit = longint'(total + reset_cycles + flush_cycles + margin_cycles) * clk_period;
        fork
            begin
                #(limit);
                stop_with_failure("Timeout, the run did not finish within the stimulus length");
            end
        join_none
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        // Output must read zero straight after reset
        @(negedge clk);
        compare_outputs();
        foreach (kinds[i]) begin
            run_segment(i);
        end
        // Let the last flags reach the output
        repeat (flush_cycles) step(1'b0, -1);
        if (m_state != counter_host_pkg::armed) begin
            stop_with_failure("The key never reached the trigger byte, the trojan stayed dormant");
        end else begin
            verdict_printed = 1'b1;
            $display("sim passed");
            $finish;
        end
    end

    // Run stopped by an assertion without a verdict line
    final begin
        if (!verdict_printed) begin
            $display("sim failed");
        end
    end

endmodule

// ==== trojan0.sv ====
// ##################
// Key-triggered trojan: arms on the trigger byte, then leaks LFSR data.
// The load is zero while dormant.
// ##################
`timescale 1ns/1ps
`include "counter_host_params.svh"

module trojan0 (
    input  logic                    clk,
    input  logic                    rst,
    input  counter_host_pkg::key_t  key,
    output counter_host_pkg::load_t load
);

    localparam int load_bits = `LOAD_WIDTH;

    counter_host_pkg::trojan_state_e state;
    counter_host_pkg::trojan_state_e state_next;

    counter_host_pkg::load_t lfsr;
    counter_host_pkg::load_t lfsr_next;
    logic                    feedback;
    logic                    trigger_hit;

    // Fibonacci taps 64, 63, 61, 60
    assign feedback  = lfsr[63] ^ lfsr[62] ^ lfsr[60] ^ lfsr[59];
    assign lfsr_next = {lfsr[load_bits-2:0], feedback};

    // Leak LFSR runs every clock, enable has no effect here
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= `LEAK_SEED;
        end else begin
            lfsr <= lfsr_next;
        end
    end

    assign trigger_hit = (key[7:0] == `TRIGGER_BYTE);

    // Two-state FSM, armed never falls back
    always_comb begin
        state_next = state;
        case (state)
            counter_host_pkg::dormant: begin
                if (trigger_hit) begin
                    state_next = counter_host_pkg::armed;
                end
            end
            counter_host_pkg::armed: begin
                state_next = counter_host_pkg::armed;
            end
            default: begin
                state_next = counter_host_pkg::dormant;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= counter_host_pkg::dormant;
        end else begin
            state <= state_next;
        end
    end

    // Payload masked by the key while armed
    always_comb begin
        if (state == counter_host_pkg::armed) begin
            load = lfsr ^ key[load_bits-1:0];
        end else begin
            load = '0;
        end
    end

endmodule

// ==== trojan0_counter_host.sv ====
// ##################
// Counter host top: event counter beside the key and trojan chain,
// both merged by the output mixer.
// ##################
`timescale 1ns/1ps

module trojan0_counter_host (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        enable,
    output counter_host_pkg::host_out_t host_out
);

    counter_host_pkg::counter_status_t counter_status;
    counter_host_pkg::key_t            key;
    counter_host_pkg::load_t           load;

    // Timing half
    event_counter u_event_counter (
        .clk            (clk),
        .rst            (rst),
        .enable         (enable),
        .counter_status (counter_status)
    );

    // Key source, folds in the count byte
    key_sequencer u_key_sequencer (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .count  (counter_status.count),
        .key    (key)
    );

    trojan0 u_trojan0 (
        .clk  (clk),
        .rst  (rst),
        .key  (key),
        .load (load)
    );

    // Registered host output
    count_mixer u_count_mixer (
        .clk            (clk),
        .rst            (rst),
        .counter_status (counter_status),
        .load           (load),
        .host_out       (host_out)
    );

endmodule
